/* rtl/stream_pkg.sv */
`default_nettype none

package stream_pkg;

    // beat and word widths.
    localparam int BEAT_W = 16;
    localparam int WORD_W = 64;

    // beats gathered into one packed word.
    localparam int BEATS_PER_WORD = WORD_W / BEAT_W;

    // word entries in the buffer FIFO.
    localparam int FIFO_DEPTH = 4;

    // one stream beat.
    typedef logic [BEAT_W-1:0] beat_t;

    // one packed word, beat 0 in the low bits.
    typedef logic [WORD_W-1:0] word_t;

    // counts 0 to BEATS_PER_WORD inclusive.
    typedef logic [2:0] beat_cnt_t;

    // FIFO read and write pointers, wrap at FIFO_DEPTH.
    typedef logic [1:0] fifo_ptr_t;

    // FIFO occupancy, 0 to FIFO_DEPTH.
    typedef logic [2:0] fifo_cnt_t;

endpackage

`default_nettype wire

/* rtl/stream_if.sv */
`timescale 1ns/1ps
`default_nettype none

interface stream_if #(
    parameter int DATA_W = 16
) ();

    logic              valid;
    logic              ready;
    logic              last;
    logic [DATA_W-1:0] data;

    // producer side.
    modport source (
        output valid,
        output last,
        output data,
        input  ready
    );

    // consumer side.
    modport sink (
        input  valid,
        input  last,
        input  data,
        output ready
    );

endinterface

`default_nettype wire

/* rtl/stream_packer.sv */
`timescale 1ns/1ps
`default_nettype none

module stream_packer
    import stream_pkg::*;
(
    input  wire      CLK,
    input  wire      RST_N,
    stream_if.sink   in_beat,
    stream_if.source out_word
);

    beat_cnt_t shift_cnt;
    word_t     shift_word;
    logic      last_q;

    logic word_vld;
    logic beat_take;
    logic word_take;

    // a full word sits in the register once four beats are in.
    assign word_vld = (shift_cnt == beat_cnt_t'(BEATS_PER_WORD));

    // room for a beat unless a full word is stuck.
    assign in_beat.ready = !word_vld || out_word.ready;

    assign beat_take = in_beat.valid && in_beat.ready;
    assign word_take = word_vld && out_word.ready;

    assign out_word.valid = word_vld;
    assign out_word.data  = shift_word;
    assign out_word.last  = last_q && word_vld;

    // beat counter.
    always_ff @(posedge CLK or negedge RST_N) begin
        if (!RST_N) begin
            shift_cnt <= '0;
        end else begin
            if (beat_take && !word_vld) begin
                shift_cnt <= shift_cnt + beat_cnt_t'(1);
            end else if (beat_take && word_take) begin
                // first beat of the next word arrives as the old one leaves.
                shift_cnt <= beat_cnt_t'(1);
            end else if (word_take) begin
                shift_cnt <= '0;
            end
        end
    end

    // new beat enters at the top, older beats move down.
    // after four beats, beat 0 ends up in the low bits.
    always_ff @(posedge CLK) begin
        if (beat_take) begin
            shift_word <= {beat_t'(in_beat.data), shift_word[WORD_W-1:BEAT_W]};
            last_q     <= in_beat.last;
        end
    end

endmodule

`default_nettype wire

/* rtl/word_fifo.sv */
`timescale 1ns/1ps
`default_nettype none

module word_fifo
    import stream_pkg::*;
(
    input  wire      CLK,
    input  wire      RST_N,
    stream_if.sink   wr,
    stream_if.source rd
);

    // storage, data and last flag side by side.
    word_t mem_data [FIFO_DEPTH];
    logic  mem_last [FIFO_DEPTH];

    fifo_ptr_t wr_ptr;
    fifo_ptr_t rd_ptr;
    fifo_cnt_t count;

    logic wr_take;
    logic rd_take;

    // ready depends on the count alone, never on a read this cycle.
    assign wr.ready = (count < fifo_cnt_t'(FIFO_DEPTH));

    assign rd.valid = (count != '0);
    assign rd.data  = mem_data[rd_ptr];
    assign rd.last  = mem_last[rd_ptr];

    assign wr_take = wr.valid && wr.ready;
    assign rd_take = rd.valid && rd.ready;

    // write side.
    always_ff @(posedge CLK) begin
        if (wr_take) begin
            mem_data[wr_ptr] <= wr.data;
            mem_last[wr_ptr] <= wr.last;
        end
    end

    // pointers wrap on their own at FIFO_DEPTH.
    always_ff @(posedge CLK or negedge RST_N) begin
        if (!RST_N) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (wr_take) begin
                wr_ptr <= wr_ptr + fifo_ptr_t'(1);
            end
            if (rd_take) begin
                rd_ptr <= rd_ptr + fifo_ptr_t'(1);
            end
        end
    end

    // occupancy.
    always_ff @(posedge CLK or negedge RST_N) begin
        if (!RST_N) begin
            count <= '0;
        end else begin
            case ({wr_take, rd_take})
                2'b10: begin
                    count <= count + fifo_cnt_t'(1);
                end
                2'b01: begin
                    count <= count - fifo_cnt_t'(1);
                end
                default: begin
                    // both or neither, level unchanged.
                    count <= count;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

/* rtl/stream_unpacker.sv */
`timescale 1ns/1ps
`default_nettype none

module stream_unpacker
    import stream_pkg::*;
(
    input  wire      CLK,
    input  wire      RST_N,
    stream_if.sink   in_word,
    stream_if.source out_beat
);

    word_t     word_q;
    logic      last_q;
    beat_cnt_t beats_left;

    logic final_beat;
    logic word_take;
    logic beat_take;

    assign final_beat = (beats_left == beat_cnt_t'(1));

    // low beat always on the output.
    assign out_beat.valid = (beats_left != '0);
    assign out_beat.data  = word_q[BEAT_W-1:0];
    assign out_beat.last  = last_q && final_beat;

    assign beat_take = out_beat.valid && out_beat.ready;

    // next word can load as the final beat goes out.
    assign in_word.ready = (beats_left == '0) || (final_beat && out_beat.ready);
    assign word_take     = in_word.valid && in_word.ready;

    // beats still to send.
    always_ff @(posedge CLK or negedge RST_N) begin
        if (!RST_N) begin
            beats_left <= '0;
        end else begin
            if (word_take) begin
                beats_left <= beat_cnt_t'(BEATS_PER_WORD);
            end else if (beat_take) begin
                beats_left <= beats_left - beat_cnt_t'(1);
            end
        end
    end

    // word register, moves down one beat per transfer.
    always_ff @(posedge CLK) begin
        if (word_take) begin
            word_q <= in_word.data;
            last_q <= in_word.last;
        end else if (beat_take) begin
            word_q <= {{BEAT_W{1'b0}}, word_q[WORD_W-1:BEAT_W]};
        end
    end

endmodule

`default_nettype wire

/* rtl/width_loop_top.sv */
`timescale 1ns/1ps
`default_nettype none

module width_loop_top
    import stream_pkg::*;
(
    input  wire   CLK,
    input  wire   RST_N,

    input  wire   in_valid,
    output logic  in_ready,
    input  beat_t in_data,
    input  wire   in_last,

    output logic  out_valid,
    input  wire   out_ready,
    output beat_t out_data,
    output logic  out_last
);

    stream_if #(.DATA_W(BEAT_W)) beat_in  ();
    stream_if #(.DATA_W(WORD_W)) pack_word ();
    stream_if #(.DATA_W(WORD_W)) buf_word  ();
    stream_if #(.DATA_W(BEAT_W)) beat_out ();

    // input stream onto the beat interface.
    assign beat_in.valid = in_valid;
    assign beat_in.data  = in_data;
    assign beat_in.last  = in_last;
    assign in_ready      = beat_in.ready;

    // 16 to 64.
    stream_packer i_packer (
        .CLK      (CLK),
        .RST_N    (RST_N),
        .in_beat  (beat_in),
        .out_word (pack_word)
    );

    word_fifo i_fifo (
        .CLK   (CLK),
        .RST_N (RST_N),
        .wr    (pack_word),
        .rd    (buf_word)
    );

    // 64 back to 16.
    stream_unpacker i_unpacker (
        .CLK      (CLK),
        .RST_N    (RST_N),
        .in_word  (buf_word),
        .out_beat (beat_out)
    );

    // output stream.
    assign out_valid      = beat_out.valid;
    assign out_data       = beat_out.data;
    assign out_last       = beat_out.last;
    assign beat_out.ready = out_ready;

endmodule

`default_nettype wire

/* tests/width_loop_props.sv */
`timescale 1ns/1ps
`default_nettype none

module width_loop_props
    import stream_pkg::*;
(
    input wire   CLK,
    input wire   RST_N,
    input wire   in_valid,
    input wire   in_ready,
    input beat_t in_data,
    input wire   in_last,
    input wire   out_valid,
    input wire   out_ready,
    input beat_t out_data,
    input wire   out_last
);

    // stalled input beat stays put.
    in_hold: assert property (@(posedge CLK) disable iff (!RST_N)
        (in_valid && !in_ready) |=> (in_valid && $stable(in_data) && $stable(in_last)))
        else $error("input beat changed or dropped while stalled");

    // stalled output beat stays put.
    out_hold: assert property (@(posedge CLK) disable iff (!RST_N)
        (out_valid && !out_ready) |=> (out_valid && $stable(out_data) && $stable(out_last)))
        else $error("output beat changed or dropped while stalled");

    // nothing on the output right out of reset.
    out_idle: assert property (@(posedge CLK) $rose(RST_N) |-> !out_valid)
        else $error("out_valid high in the first cycle after reset");

endmodule

bind width_loop_top width_loop_props i_props (
    .CLK       (CLK),
    .RST_N     (RST_N),
    .in_valid  (in_valid),
    .in_ready  (in_ready),
    .in_data   (in_data),
    .in_last   (in_last),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .out_data  (out_data),
    .out_last  (out_last)
);

`default_nettype wire

/* tests/tb_width_loop.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_width_loop
    import stream_pkg::*;
();

    localparam int CLK_PERIOD = 20;
    localparam int DRIVE_DLY  = 2;
    localparam logic [31:0] SEED = 32'hd2b51680;

    // out_ready behaviour.
    localparam int READY_HIGH   = 0;
    localparam int READY_RANDOM = 1;
    localparam int READY_LOW    = 2;

    localparam int MAX_GROUPS  = 6;
    localparam int PASS_PKTS   = 8;
    localparam int RAND_PKTS   = 12;
    localparam int HOLD_GROUPS = 8;

    // one word in the packer, FIFO_DEPTH words buffered, one word in the unpacker.
    localparam int HOLD_MAX = BEATS_PER_WORD * (FIFO_DEPTH + 2);

    // quiet cycles watched on the output once the model has emptied.
    localparam int QUIET_CYCLES = 2 * BEATS_PER_WORD;

    localparam int TOTAL_BEATS = (PASS_PKTS + RAND_PKTS) * MAX_GROUPS * BEATS_PER_WORD
                                 + HOLD_GROUPS * BEATS_PER_WORD;
    localparam int CYCLE_LIMIT = 8 * TOTAL_BEATS + 200;

    logic  CLK;
    logic  RST_N;
    logic  in_valid;
    logic  in_ready;
    beat_t in_data;
    logic  in_last;
    logic  out_valid;
    logic  out_ready;
    beat_t out_data;
    logic  out_last;

    // expected beats, {last, data}.
    logic [BEAT_W:0] model_q [$];

    logic [31:0] stim_state;
    logic [31:0] ready_state;
    int          ready_mode;
    int          in_beats;
    int          cycle_cnt;
    int          error_cnt;
    string       test_name;

    width_loop_top i_dut (
        .CLK       (CLK),
        .RST_N     (RST_N),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .in_data   (in_data),
        .in_last   (in_last),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_data  (out_data),
        .out_last  (out_last)
    );

    always #(CLK_PERIOD / 2) CLK = ~CLK;

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic logic [31:0] next_stim();
        stim_state = lcg_next(stim_state);
        return stim_state;
    endfunction

    function automatic int random_groups();
        logic [31:0] r;
        r = next_stim();
        return 1 + int'(r[31:16]) % MAX_GROUPS;
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            error_cnt++;
            $display("Error: %s expected 0x%0h actual 0x%0h", name, expected, actual);
            $display("Finished with errors");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic align_drive();
        @(posedge CLK);
        #DRIVE_DLY;
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) begin
            align_drive();
        end
    endtask

    // called just after a rising edge, returns just after the edge that took the beat.
    task automatic send_beat(input beat_t data, input logic last);
        in_valid = 1'b1;
        in_data  = data;
        in_last  = last;
        @(negedge CLK);
        while (!in_ready) begin
            @(negedge CLK);
        end
        align_drive();
        in_valid = 1'b0;
    endtask

    task automatic send_packet(input int groups, input bit gaps);
        logic [31:0] r;
        int          beats;
        beats = groups * BEATS_PER_WORD;
        for (int i = 0; i < beats; i++) begin
            r = next_stim();
            if (gaps && r[15:14] == 2'b00) begin
                idle_cycles(1 + int'(r[13:12]));
            end
            send_beat(r[31:16], i == beats - 1);
        end
    endtask

    // returns on a falling edge once the model is empty and the output stays quiet.
    task automatic wait_drain();
        @(negedge CLK);
        while (model_q.size() != 0) begin
            @(negedge CLK);
        end
        repeat (QUIET_CYCLES) begin
            @(negedge CLK);
            check_value({test_name, ": out_valid after drain"}, 0, 32'(out_valid));
        end
    endtask

    // out_ready driver.
    always @(posedge CLK) begin
        #DRIVE_DLY;
        case (ready_mode)
            READY_RANDOM: begin
                ready_state = lcg_next(ready_state);
                out_ready   = (ready_state[31:30] != 2'b00);
            end
            READY_LOW: begin
                out_ready = 1'b0;
            end
            default: begin
                out_ready = 1'b1;
            end
        endcase
    end

    // handshakes sampled mid cycle, the transfer lands on the next rising edge.
    always @(negedge CLK) begin
        logic [BEAT_W:0] expected;
        if (RST_N) begin
            if (in_valid && in_ready) begin
                model_q.push_back({in_last, in_data});
                in_beats++;
            end
            if (out_valid && out_ready) begin
                if (model_q.size() == 0) begin
                    $display("%s: output beat arrived with nothing left in the model",
                             test_name);
                    $display("Finished with errors");
                    $fatal(1, "unexpected output beat");
                end else begin
                    expected = model_q.pop_front();
                    check_value({test_name, ": out_data"}, 32'(expected[BEAT_W-1:0]),
                                32'(out_data));
                    check_value({test_name, ": out_last"}, 32'(expected[BEAT_W]),
                                32'(out_last));
                end
            end
        end
    end

    always @(posedge CLK) begin
        cycle_cnt++;
        if (cycle_cnt > CYCLE_LIMIT) begin
            $display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("Finished with errors");
            $fatal(1, "cycle limit reached");
        end
    end

    initial begin
        int held;
        int stalled;
        int start_beats;

        CLK         = 1'b0;
        RST_N       = 1'b0;
        in_valid    = 1'b0;
        in_data     = '0;
        in_last     = 1'b0;
        out_ready   = 1'b1;
        ready_mode  = READY_HIGH;
        stim_state  = SEED;
        ready_state = lcg_next(SEED);
        in_beats    = 0;
        cycle_cnt   = 0;
        error_cnt   = 0;
        test_name   = "reset";

        repeat (3) @(posedge CLK);
        #DRIVE_DLY;
        RST_N = 1'b1;
        @(negedge CLK);
        check_value("reset: out_valid", 0, 32'(out_valid));
        check_value("reset: in_ready", 1, 32'(in_ready));

        // steady output.
        test_name = "pass_through";
        align_drive();
        repeat (PASS_PKTS) begin
            send_packet(random_groups(), 1'b0);
        end
        wait_drain();

        // random back-pressure and input gaps.
        test_name  = "random_ready";
        ready_mode = READY_RANDOM;
        align_drive();
        repeat (RAND_PKTS) begin
            send_packet(random_groups(), 1'b1);
        end
        wait_drain();

        // output blocked until the input stalls.
        test_name   = "back_pressure";
        ready_mode  = READY_LOW;
        start_beats = in_beats;
        align_drive();
        fork
            send_packet(HOLD_GROUPS, 1'b0);
            begin
                stalled = 0;
                while (stalled < 4) begin
                    @(negedge CLK);
                    if (in_valid && !in_ready) begin
                        stalled++;
                    end else begin
                        stalled = 0;
                    end
                end
                held = in_beats - start_beats;
                check_value("back_pressure: held beats within limit", 1,
                            32'(held <= HOLD_MAX));
                ready_mode = READY_HIGH;
            end
        join
        wait_drain();

        if (error_cnt == 0) begin
            $display("Finished with no errors");
            $finish;
        end else begin
            $display("Finished with errors");
            $fatal(1, "checks failed");
        end
    end

endmodule

`default_nettype wire

/* sources.f */
rtl/stream_pkg.sv
rtl/stream_if.sv
rtl/stream_packer.sv
rtl/word_fifo.sv
rtl/stream_unpacker.sv
rtl/width_loop_top.sv
tests/width_loop_props.sv
tests/tb_width_loop.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert
TOP       = tb_width_loop
FILELIST  = sources.f
BUILD_DIR = obj_dir
PASS_MSG  = Finished with no errors

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

# the run passes only when the pass message shows up in the output.
run: build
	@out="$$(./$(BUILD_DIR)/V$(TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

lint:
	$(VERILATOR) --lint-only --timing --assert --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)
